/* src/muldiv_types_pkg.sv */
/*
 * muldiv types: operation encoding and datapath sizes shared by the
 * multiply/divide unit and its testbench
 */
package muldiv_types_pkg;

  // --------------------
  // operation encoding
  // --------------------

  // op_mul is a signed multiply; both divides share the restoring engine
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } muldiv_op_t;

  // --------------------
  // sizes
  // --------------------

  // operand size in bits
  localparam int operand_width = 32;
  // full product, or remainder in the upper half and quotient in the lower
  localparam int result_width = 64;
  // radix-2 engines retire one bit per cycle
  localparam int num_iters = 32;

endpackage

/* src/muldiv_ctrl_pkg.sv */
/*
 * muldiv controller definitions: FSM state encoding and iteration counter size
 */
package muldiv_ctrl_pkg;

  // idle waits for a request, iterate runs the engines,
  // fixup registers the signed result, done holds it for the consumer
  typedef enum logic [1:0] {
    idle    = 2'd0,
    iterate = 2'd1,
    fixup   = 2'd2,
    done    = 2'd3
  } ctrl_state_t;

  // wide enough to count num_iters steps, 0 up to 31
  localparam int iter_count_width = 5;

endpackage

/* src/muldiv_step_if.sv */
/*
 * muldiv step bus: single-cycle commands from the controller FSM
 * to the sign unit and both iterative engines
 */
`timescale 1ns/1ns

interface muldiv_step_if;

  // capture operands, on the accepting edge
  logic load;
  // one radix-2 iteration
  logic step;
  // register the signed result
  logic fixup;
  // picks the divider output at fixup, held for the whole operation
  logic is_div;

  // --------------------
  // modports
  // --------------------

  // controller drives every strobe
  modport ctrl (
    output load,
    output step,
    output fixup,
    output is_div
  );

  // datapath modules only listen
  modport dpath (
    input load,
    input step,
    input fixup,
    input is_div
  );

endinterface

/* src/operand_sign_unit.sv */
/*
 * operand sign unit: strips operand signs before the engines run and
 * reapplies them to the product or the quotient and remainder afterwards
 */
`timescale 1ns/1ns

module operand_sign_unit
  import muldiv_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [operand_width-1:0] req_a,
  input  logic [operand_width-1:0] req_b,
  input  muldiv_op_t               req_op,
  muldiv_step_if.dpath             step_bus,
  output logic [operand_width-1:0] a_mag,
  output logic [operand_width-1:0] b_mag,
  input  logic [result_width-1:0]  mul_mag,
  input  logic [operand_width-1:0] quot_mag,
  input  logic [operand_width-1:0] rem_mag,
  output logic [result_width-1:0]  resp_result
);

  // --------------------
  // operand side
  // --------------------

  logic signed_op;
  logic a_neg;
  logic b_neg;

  // unsigned divide never treats the top bit as a sign
  assign signed_op = (req_op != op_divu);
  assign a_neg = signed_op & req_a[operand_width-1];
  assign b_neg = signed_op & req_b[operand_width-1];

  // magnitudes go straight to the engines, which capture them on load
  // most-negative value maps onto itself, read as unsigned 2^31
  assign a_mag = a_neg ? -req_a : req_a;
  assign b_mag = b_neg ? -req_b : req_b;

  // signs of the operation in flight
  logic a_neg_q;
  logic b_neg_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg_q <= 1'b0;
      b_neg_q <= 1'b0;
    end else if (step_bus.load) begin
      a_neg_q <= a_neg;
      b_neg_q <= b_neg;
    end
  end

  // --------------------
  // result side
  // --------------------

  logic                     neg_result;
  logic [result_width-1:0]  prod_signed;
  logic [operand_width-1:0] quot_signed;
  logic [operand_width-1:0] rem_signed;
  logic [result_width-1:0]  result_q;

  // product and quotient flip when exactly one operand was negative
  assign neg_result  = a_neg_q ^ b_neg_q;
  assign prod_signed = neg_result ? -mul_mag : mul_mag;
  assign quot_signed = neg_result ? -quot_mag : quot_mag;
  // remainder follows the dividend
  assign rem_signed  = a_neg_q ? -rem_mag : rem_mag;

  // result register, held until the next fixup
  always_ff @(posedge clk) begin
    if (step_bus.fixup) begin
      if (step_bus.is_div)
        result_q <= {rem_signed, quot_signed};
      else
        result_q <= prod_signed;
    end
  end

  assign resp_result = result_q;

endmodule

/* src/mul_shift_add.sv */
/*
 * shift-and-add multiplier: one radix-2 partial product per step
 * on operand magnitudes, full 64-bit unsigned product
 */
`timescale 1ns/1ns

module mul_shift_add
  import muldiv_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  muldiv_step_if.dpath             step_bus,
  input  logic [operand_width-1:0] a_mag,
  input  logic [operand_width-1:0] b_mag,
  output logic [result_width-1:0]  mul_mag
);

  // multiplicand moves left one place per step
  logic [result_width-1:0]  mcand_q;
  // multiplier moves right, bit 0 picks the add
  logic [operand_width-1:0] mplier_q;
  // running sum of partial products
  logic [result_width-1:0]  acc_q;

  logic [result_width-1:0]  acc_next;

  // add the shifted multiplicand only where the multiplier bit is set
  assign acc_next = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  // --------------------
  // iteration registers
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (step_bus.load) begin
      acc_q <= '0;
    end else if (step_bus.step) begin
      acc_q <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (step_bus.load) begin
      // zero-extend into the upper half
      mcand_q  <= {{(result_width-operand_width){1'b0}}, a_mag};
      mplier_q <= b_mag;
    end else if (step_bus.step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // after 32 steps every multiplier bit has been consumed
  assign mul_mag = acc_q;

endmodule

/* src/div_restoring.sv */
/*
 * restoring divider: one quotient bit per step on operand magnitudes,
 * remainder and quotient share one 64-bit shift register
 */
`timescale 1ns/1ns

module div_restoring
  import muldiv_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  muldiv_step_if.dpath             step_bus,
  input  logic [operand_width-1:0] a_mag,
  input  logic [operand_width-1:0] b_mag,
  output logic [operand_width-1:0] quot_mag,
  output logic [operand_width-1:0] rem_mag
);

  // upper half partial remainder, lower half dividend bits then quotient bits
  logic [result_width-1:0]  rq_q;
  logic [operand_width-1:0] divisor_q;

  // --------------------
  // one restoring step
  // --------------------

  // partial remainder after the shift, 33 bits since 2*rem+1 can pass 2^32
  logic [operand_width:0]   partial;
  // trial subtraction, top bit is the borrow
  logic [operand_width:0]   diff;
  logic                     no_borrow;
  logic [operand_width-1:0] rem_next;
  logic [result_width-1:0]  rq_next;

  assign partial   = rq_q[result_width-1:operand_width-1];
  assign diff      = partial - {1'b0, divisor_q};
  assign no_borrow = ~diff[operand_width];

  // keep the difference when it fits, otherwise restore the shifted value
  assign rem_next = no_borrow ? diff[operand_width-1:0] : partial[operand_width-1:0];

  // quotient bit enters at the bottom as the dividend bits move up
  assign rq_next = {rem_next, rq_q[operand_width-2:0], no_borrow};

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q <= '0;
    end else if (step_bus.load) begin
      rq_q <= {{operand_width{1'b0}}, a_mag};
    end else if (step_bus.step) begin
      rq_q <= rq_next;
    end
  end

  // divisor held for the whole operation
  always_ff @(posedge clk) begin
    if (step_bus.load)
      divisor_q <= b_mag;
  end

  // --------------------
  // results
  // --------------------

  // a zero divisor never borrows, so the quotient fills with ones
  // and the dividend ends up in the remainder
  assign quot_mag = rq_q[operand_width-1:0];
  assign rem_mag  = rq_q[result_width-1:operand_width];

endmodule

/* src/muldiv_ctrl.sv */
/*
 * muldiv controller: FSM that sequences load, 32 iteration steps,
 * sign fixup and the val/rdy response handshake
 */
`timescale 1ns/1ns

module muldiv_ctrl
  import muldiv_types_pkg::*;
  import muldiv_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         req_val,
  output logic         req_rdy,
  output logic         resp_val,
  input  logic         resp_rdy,
  input  muldiv_op_t   req_op,
  muldiv_step_if.ctrl  step_bus
);

  ctrl_state_t                 state_q;
  ctrl_state_t                 state_next;
  logic [iter_count_width-1:0] count_q;
  // divide or multiply, registered with the operands
  logic                        div_q;

  logic req_fire;
  logic resp_fire;
  logic last_step;

  // --------------------
  // handshake decode
  // --------------------

  // only idle takes a request, only done offers a response
  assign req_rdy  = (state_q == idle);
  assign resp_val = (state_q == done);

  assign req_fire  = req_val & req_rdy;
  assign resp_fire = resp_val & resp_rdy;

  // count_q reaches 31 on the 32nd step
  assign last_step = (count_q == iter_count_width'(num_iters - 1));

  // --------------------
  // step strobes
  // --------------------

  assign step_bus.load   = req_fire;
  assign step_bus.step   = (state_q == iterate);
  assign step_bus.fixup  = (state_q == fixup);
  assign step_bus.is_div = div_q;

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state_q;
    case (state_q)
      idle: begin
        if (req_fire)
          state_next = iterate;
      end
      iterate: begin
        if (last_step)
          state_next = fixup;
      end
      // one cycle to register the signed result
      fixup: state_next = done;
      // result held under back-pressure
      done: begin
        if (resp_fire)
          state_next = idle;
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      count_q <= '0;
      div_q   <= 1'b0;
    end else begin
      state_q <= state_next;
      // counter restarts with every accepted request
      if (req_fire) begin
        count_q <= '0;
        div_q   <= (req_op != op_mul);
      end else if (state_q == iterate) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

/* src/muldiv_unit.sv */
/*
 * muldiv unit: iterative 32-bit multiply/divide with val/rdy request
 * and response ports, one operation in flight
 */
`timescale 1ns/1ns

module muldiv_unit
  import muldiv_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [operand_width-1:0] req_a,
  input  logic [operand_width-1:0] req_b,
  input  muldiv_op_t               req_op,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic [result_width-1:0]  resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // controller strobes to the datapath
  muldiv_step_if step_bus ();

  // magnitudes into the engines, magnitude results back out
  logic [operand_width-1:0] a_mag;
  logic [operand_width-1:0] b_mag;
  logic [result_width-1:0]  mul_mag;
  logic [operand_width-1:0] quot_mag;
  logic [operand_width-1:0] rem_mag;

  // --------------------
  // control
  // --------------------

  muldiv_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .req_op   (req_op),
    .step_bus (step_bus.ctrl)
  );

  // --------------------
  // datapath
  // --------------------

  operand_sign_unit sign (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .step_bus    (step_bus.dpath),
    .a_mag       (a_mag),
    .b_mag       (b_mag),
    .mul_mag     (mul_mag),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .resp_result (resp_result)
  );

  // both engines run on every operation, fixup picks one
  mul_shift_add mul (
    .clk      (clk),
    .reset    (reset),
    .step_bus (step_bus.dpath),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .mul_mag  (mul_mag)
  );

  div_restoring div (
    .clk      (clk),
    .reset    (reset),
    .step_bus (step_bus.dpath),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

endmodule

/* bench/muldiv_properties.sv */
/*
 * Handshake properties of the multiply/divide controller. Busy until the
 * response is taken, response hold and fixed latency, bound into muldiv_ctrl
 */
`timescale 1ns/1ns

module muldiv_properties (
  input logic clk,
  input logic reset,
  input logic req_val,
  input logic req_rdy,
  input logic resp_val,
  input logic resp_rdy
);

  // assertion failures so far
  int failures = 0;

  // no new request from acceptance until the response is taken
  busy_until_taken: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) || (!req_rdy && !(resp_val && resp_rdy)) |=> !req_rdy)
    else begin
      failures++;
      $error("req_rdy rose before the response was taken");
    end

  // a response not taken stays offered
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else begin
      failures++;
      $error("resp_val dropped before the response was taken");
    end

  // 32 steps plus one fixup cycle for any operands
  fixed_latency: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> !resp_val [*33] ##1 resp_val)
    else begin
      failures++;
      $error("resp_val did not rise 33 cycles after the request was accepted");
    end

endmodule

bind muldiv_ctrl muldiv_properties props (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

/* bench/muldiv_checker.sv */
/*
 * Checker for the multiply/divide unit. Models each accepted request and
 * compares the response, its latency and its stability under back-pressure
 */
`timescale 1ns/1ns

module muldiv_checker
  import muldiv_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [operand_width-1:0] req_a,
  input  logic [operand_width-1:0] req_b,
  input  muldiv_op_t               req_op,
  input  logic                     req_val,
  input  logic                     req_rdy,
  input  logic [result_width-1:0]  resp_result,
  input  logic                     resp_val,
  input  logic                     resp_rdy,
  output int                       pass_count,
  output int                       fail_count,
  output int                       accept_count,
  output int                       resp_count
);

  // requests accepted and not yet answered
  logic [result_width-1:0] expect_q[$];
  muldiv_op_t              op_q[$];
  int                      accept_cycle_q[$];

  int                      cycle;
  logic                    was_reset;
  // response offered last cycle and not taken
  logic                    held_val;
  logic [result_width-1:0] held_result;
  logic                    resp_val_prev;

  // --------------------
  // reference model
  // --------------------

  function automatic logic [result_width-1:0] model_result(
    input logic [operand_width-1:0] a,
    input logic [operand_width-1:0] b,
    input muldiv_op_t               op
  );
    longint                   sa;
    longint                   sb;
    logic [operand_width-1:0] q;
    logic [operand_width-1:0] r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (op == op_mul)
      return sa * sb;
    if (b == '0) begin
      // all-ones quotient magnitude is negated only for a negative signed dividend
      q = (op == op_div && a[operand_width-1]) ? 32'h1 : 32'hffffffff;
      r = a;
    end else if (op == op_divu) begin
      q = a / b;
      r = a % b;
    end else begin
      // 64-bit divide lets 0x80000000 / -1 wrap in the low half
      q = operand_width'(sa / sb);
      r = operand_width'(sa % sb);
    end
    return {r, q};
  endfunction

  initial begin
    pass_count   = 0;
    fail_count   = 0;
    accept_count = 0;
    resp_count   = 0;
    cycle        = 0;
    was_reset    = 1'b1;
    held_val     = 1'b0;
    held_result  = '0;
    resp_val_prev = 1'b0;
  end

  // --------------------
  // monitor
  // --------------------

  // inputs and outputs are settled at the falling edge
  always @(negedge clk) begin
    cycle++;
    if (reset) begin
      was_reset = 1'b1;
      held_val  = 1'b0;
      resp_val_prev = 1'b0;
    end else begin
      // first cycle out of reset
      if (was_reset) begin
        if (req_rdy && !resp_val) begin
          pass_count++;
          $display("test reset: req_rdy high, resp_val low");
        end else begin
          fail_count++;
          $display("Mismatch req_rdy/resp_val after reset: got %h/%h expected 1/0",
                   req_rdy, resp_val);
        end
        was_reset = 1'b0;
      end
      if (req_val && req_rdy) begin
        accept_count++;
        expect_q.push_back(model_result(req_a, req_b, req_op));
        op_q.push_back(req_op);
        accept_cycle_q.push_back(cycle);
      end
      if (resp_val && req_rdy) begin
        fail_count++;
        $display("req_rdy is high while a response is offered");
      end
      if (held_val && !resp_val) begin
        fail_count++;
        $display("resp_val dropped before the response was taken");
      end else if (held_val && resp_result !== held_result) begin
        fail_count++;
        $display("Mismatch resp_result held: got %h expected %h", resp_result, held_result);
      end
      // acceptance is sampled before its edge
      // and a response valid 33 edges later shows up 34 samples on
      if (resp_val && !resp_val_prev && accept_cycle_q.size() > 0) begin
        if (cycle - accept_cycle_q[0] != 34) begin
          fail_count++;
          $display("response became valid %0d cycles after acceptance instead of 33",
                   cycle - accept_cycle_q[0] - 1);
        end
      end
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (expect_q.size() == 0) begin
          fail_count++;
          $display("response %0d arrived with no request pending", resp_count);
        end else begin
          if (resp_result === expect_q[0]) begin
            pass_count++;
            $display("test %0d %s: result %h", resp_count, op_q[0].name(), resp_result);
          end else begin
            fail_count++;
            $display("Mismatch resp_result: got %h expected %h (test %0d %s)",
                     resp_result, expect_q[0], resp_count, op_q[0].name());
          end
          void'(expect_q.pop_front());
          void'(op_q.pop_front());
          void'(accept_cycle_q.pop_front());
        end
      end
      held_val      = resp_val && !resp_rdy;
      held_result   = resp_result;
      resp_val_prev = resp_val;
    end
  end

endmodule

/* bench/muldiv_tb.sv */
/*
 * Testbench for the multiply/divide unit. Directed corners then LFSR
 * requests with random gaps and response stalls, checked by muldiv_checker
 */
`timescale 1ns/1ns

module muldiv_tb
  import muldiv_types_pkg::*;
();

  localparam int total_tests   = 200;
  // budget per test covers the 33-cycle latency, gaps and stalls
  localparam int timeout_limit = total_tests * 40 + 400;

  logic                     clk;
  logic                     reset;
  logic [operand_width-1:0] req_a;
  logic [operand_width-1:0] req_b;
  muldiv_op_t               req_op;
  logic                     req_val;
  logic                     req_rdy;
  logic [result_width-1:0]  resp_result;
  logic                     resp_val;
  logic                     resp_rdy;

  int pass_count;
  int fail_count;
  int accept_count;
  int resp_count;

  logic [31:0] lfsr_q;
  logic [31:0] bits;
  logic        taken;
  int          sent;
  int          gap;
  int          cycle_count;

  muldiv_unit uut (.*);

  muldiv_checker check (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // random source
  // --------------------

  // Galois form of x^32 + x^22 + x^2 + x + 1 shifting right
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h80200003;
    return state >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // one in eight operands is a corner value
  task automatic random_operand(output logic [operand_width-1:0] value);
    logic [31:0] sel;
    take_bits(3, sel);
    if (sel == 0) begin
      take_bits(2, sel);
      case (sel[1:0])
        2'd0:    value = 32'h00000000;
        2'd1:    value = 32'hffffffff;
        2'd2:    value = 32'h80000000;
        default: value = 32'h7fffffff;
      endcase
    end else begin
      take_bits(32, value);
    end
  endtask

  // --------------------
  // request generation
  // --------------------

  task automatic set_request(
    input logic [operand_width-1:0] a,
    input logic [operand_width-1:0] b,
    input muldiv_op_t               op
  );
    req_a  = a;
    req_b  = b;
    req_op = op;
  endtask

  task automatic next_request(input int idx);
    logic [31:0] o;
    case (idx)
      0:  set_request(32'h00000000, 32'h12345678, op_mul);
      1:  set_request(32'hffffffff, 32'hffffffff, op_mul);
      2:  set_request(32'h80000000, 32'h80000000, op_mul);
      3:  set_request(32'h7fffffff, 32'h80000000, op_mul);
      4:  set_request(32'h7fffffff, 32'hffffffff, op_mul);
      // most-negative over minus one wraps
      5:  set_request(32'h80000000, 32'hffffffff, op_div);
      6:  set_request(32'hfffffff9, 32'h00000002, op_div);
      7:  set_request(32'h00000007, 32'hfffffffe, op_div);
      8:  set_request(32'hfffffff9, 32'h00000000, op_div);
      9:  set_request(32'hfffffff9, 32'h00000002, op_divu);
      10: set_request(32'h80000000, 32'h00000000, op_divu);
      11: set_request(32'h7fffffff, 32'hffffffff, op_divu);
      default: begin
        random_operand(req_a);
        random_operand(req_b);
        take_bits(2, o);
        req_op = (o[1:0] == 2'd3) ? op_div : muldiv_op_t'(o[1:0]);
      end
    endcase
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    lfsr_q   = 32'd70;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_op   = op_mul;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    sent     = 0;
    gap      = 0;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    while (resp_count < total_tests) begin
      @(negedge clk);
      taken = req_val && req_rdy;
      @(posedge clk);
      #1;
      if (taken) begin
        req_val = 1'b0;
        sent++;
        take_bits(1, bits);
        gap = bits;
      end
      if (!req_val && sent < total_tests) begin
        if (gap > 0) begin
          gap--;
        end else begin
          next_request(sent);
          req_val = 1'b1;
        end
      end
      // consumer stalls about one cycle in four
      take_bits(2, bits);
      resp_rdy = (bits != 0);
    end
    repeat (2) @(negedge clk);
    $display("tests %0d, passed %0d, failed %0d, accepted %0d, assertion failures %0d",
             resp_count + 1, pass_count, fail_count, accept_count, uut.ctrl.props.failures);
    if (fail_count == 0 && uut.ctrl.props.failures == 0 && accept_count == total_tests
        && pass_count == total_tests + 1)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // run limit
  initial cycle_count = 0;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("run timed out after %0d cycles with %0d of %0d responses",
               cycle_count, resp_count, total_tests);
      $display("sim failed");
      $finish;
    end
  end

endmodule

/* files.f */
src/muldiv_types_pkg.sv
src/muldiv_ctrl_pkg.sv
src/muldiv_step_if.sv
src/operand_sign_unit.sv
src/mul_shift_add.sv
src/div_restoring.sv
src/muldiv_ctrl.sv
src/muldiv_unit.sv
bench/muldiv_properties.sv
bench/muldiv_checker.sv
bench/muldiv_tb.sv
